/* dv/rvCoreGolden.hex */
// program length, then program words, then store count,
// then one line per expected store with address and data, in issue order
0000001F   // 31 program words
00500093   // 00 addi x1, x0, 5
00C00113   // 04 addi x2, x0, 12
002081B3   // 08 add  x3, x1, x2   17, forwards from memory and writeback
40118233   // 0C sub  x4, x3, x1   12
0011F2B3   // 10 and  x5, x3, x1   1
00116333   // 14 or   x6, x2, x1   13
0020A3B3   // 18 slt  x7, x1, x2   1
00112433   // 1C slt  x8, x2, x1   0
00302023   // 20 sw   x3, 0(x0)
00402223   // 24 sw   x4, 4(x0)
00502423   // 28 sw   x5, 8(x0)
00602623   // 2C sw   x6, 12(x0)
00702823   // 30 sw   x7, 16(x0)
00802A23   // 34 sw   x8, 20(x0)
FF900493   // 38 addi x9, x0, -7
00902C23   // 3C sw   x9, 24(x0)   store data forwarded
00002503   // 40 lw   x10, 0(x0)
001505B3   // 44 add  x11, x10, x1   load-use stall
00B02E23   // 48 sw   x11, 28(x0)
00108663   // 4C beq  x1, x1, +12   taken
7AD00613   // 50 addi x12, x0, 0x7ad   marker, flushed
02C02023   // 54 sw   x12, 32(x0)   flushed
00208463   // 58 beq  x1, x2, +8   not taken
02202023   // 5C sw   x2, 32(x0)
00C006EF   // 60 jal  x13, +12
7AD00613   // 64 addi x12, x0, 0x7ad   marker, flushed
02C02223   // 68 sw   x12, 36(x0)   flushed
02D02223   // 6C sw   x13, 36(x0)   link 0x64
06300013   // 70 addi x0, x0, 99
02002423   // 74 sw   x0, 40(x0)   x0 stays zero
0000006F   // 78 jal  x0, 0   park here
0000000B   // 11 expected stores
00000000 00000011   // add
00000004 0000000C   // sub
00000008 00000001   // and
0000000C 0000000D   // or
00000010 00000001   // slt true
00000014 00000000   // slt false
00000018 FFFFFFF9   // negative immediate
0000001C 00000016   // loaded value plus 5
00000020 0000000C   // not-taken path
00000024 00000064   // jal link
00000028 00000000   // x0

/* filelist.f */
verilog/rvCorePkg.sv
verilog/stageReg.sv
verilog/controlDecoder.sv
verilog/hazardUnit.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/rvCore.sv
dv/tbClock.sv
dv/rvCoreTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = rvCoreTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* dv/rvCoreTb.sv */
module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import rvCorePkg::*;

    localparam int CLK_PERIOD_NS   = 40;
    localparam int GOLDEN_DEPTH    = 128;
    localparam int IMEM_DEPTH      = 2048;   // full 11-bit word address range
    localparam int DMEM_DEPTH      = 64;
    localparam int CYCLES_PER_ITEM = 20;     // watchdog budget per word and per store

    logic      clk;
    logic      rst;
    dataWord_t imemData;
    imemAddr_t imemAddr;
    dataWord_t dmemReadData;
    logic      dmemWrite;
    dataWord_t dmemAddr;
    dataWord_t dmemWriteData;

    dataWord_t golden [0:GOLDEN_DEPTH-1];
    dataWord_t imem [0:IMEM_DEPTH-1];
    dataWord_t dmem [0:DMEM_DEPTH-1] = '{default: '0};   // data memory starts cleared

    int   progLen;
    int   storeCount;
    int   storeBase;      // golden index of the first address and data pair
    int   storesSeen = 0;
    int   budgetCycles;
    logic goldenLoaded = 1'b0;

    tbClock #(.PERIOD_NS(CLK_PERIOD_NS)) clockGen (.clk(clk));

    rvCore rvCore_inst (
        .clk(clk), .rst(rst),
        .imemData(imemData), .imemAddr(imemAddr),
        .dmemReadData(dmemReadData), .dmemWrite(dmemWrite),
        .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData)
    );

    //////////////////////////////////////////////////
    // memory models, async read
    //////////////////////////////////////////////////
    assign imemData     = imem[imemAddr];
    assign dmemReadData = dmem[dmemAddr[7:2]];   // word index inside 256 bytes

    // store lands on the rising edge with the strobe high
    always @(posedge clk) begin
        if (dmemWrite) begin
            dmem[dmemAddr[7:2]] <= dmemWriteData;
            checkStore();
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input dataWord_t got, input dataWord_t exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkImemAddr(input string name, input imemAddr_t got, input imemAddr_t exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // next golden pair against the store on the bus
    task automatic checkStore();
        int idx;
        idx = storeBase + 2 * storesSeen;
        if (storesSeen >= storeCount) begin
            abortRun($sformatf("unexpected store to 0x%h after all %0d expected stores",
                               dmemAddr, storeCount));
        end else begin
            checkWord($sformatf("dmemAddr (store %0d)", storesSeen), dmemAddr, golden[idx]);
            checkWord($sformatf("dmemWriteData (store %0d)", storesSeen), dmemWriteData,
                      golden[idx + 1]);
            storesSeen++;
        end
    endtask

    task automatic loadGolden();
        $readmemh("dv/rvCoreGolden.hex", golden);
        progLen = int'(golden[0]);
        if (progLen <= 0 || progLen > GOLDEN_DEPTH - 2) begin
            abortRun("golden file is missing or its program length is out of range");
        end
        storeCount = int'(golden[progLen + 1]);
        storeBase  = progLen + 2;
        if (storeCount <= 0 || storeBase + 2 * storeCount > GOLDEN_DEPTH) begin
            abortRun("golden file store count is out of range");
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = (i < progLen) ? golden[i + 1] : '0;   // zero word decodes as no-op
        end
        budgetCycles = CYCLES_PER_ITEM * (progLen + storeCount);
        goldenLoaded = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin : main
        rst = 1'b1;
        loadGolden();
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);   // stable point mid cycle
            checkWord("dmemWrite", dataWord_t'(dmemWrite), '0);
            checkImemAddr("imemAddr", imemAddr, '0);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkWord("dmemWrite", dataWord_t'(dmemWrite), '0);   // first cycle out of reset
        checkImemAddr("imemAddr", imemAddr, '0);

        wait (storesSeen == storeCount);
        repeat (8) @(posedge clk);   // room for a stray marker store to show up
        $display("All checks passed");
        $finish;
    end

    // watchdog sized from program length and store count
    initial begin : watchdog
        wait (goldenLoaded);
        #(budgetCycles * CLK_PERIOD_NS);
        abortRun($sformatf("timeout, only %0d of %0d expected stores arrived",
                           storesSeen, storeCount));
    end

endmodule

/* dv/tbClock.sv */
module tbClock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // free running, low for the first half period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

/* verilog/rvCore.sv */
module rvCore (
    input  logic                   clk,
    input  logic                   rst,
    // instruction memory, async read
    input  rvCorePkg::dataWord_t   imemData,
    output rvCorePkg::imemAddr_t   imemAddr,
    // data memory, async read
    input  rvCorePkg::dataWord_t   dmemReadData,
    output logic                   dmemWrite,
    output rvCorePkg::dataWord_t   dmemAddr,
    output rvCorePkg::dataWord_t   dmemWriteData
);
    import rvCorePkg::*;

    // fetch
    dataWord_t      pcF, pcPlus4F, pcNextF;
    fetchToDecode_t fdF, fdD;
    // decode
    regAddr_t       rs1D, rs2D, rdD;
    logic           regWriteD, aluSrcD, memWriteD, jumpD, branchD;
    immSrc_t        immSrcD;
    resultSrc_t     resultSrcD;
    aluOp_t         aluOpD;
    dataWord_t      readData1D, readData2D, immExtD;
    decodeToExec_t  deD, deE;
    // execute
    dataWord_t      aluResultE, writeDataE, pcTargetE;
    logic           zeroE, redirectE, loadE;
    execToMem_t     emE, emM;
    // memory, writeback
    memToWb_t       mwM, mwW;
    dataWord_t      resultW;
    // hazards
    forwardSel_t    forwardA, forwardB;
    logic           stallF, stallD, flushD, flushE;

    //////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////
    assign pcPlus4F = pcF + 32'd4;
    assign pcNextF  = redirectE ? pcTargetE : pcPlus4F;   // redirect from execute

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pcF <= '0;
        end else if (!stallF) begin
            pcF <= pcNextF;
        end
    end

    assign imemAddr = pcF[IMEM_ADDR_LSB +: IMEM_ADDR_W];

    always_comb begin
        fdF.instr   = imemData;
        fdF.pc      = pcF;
        fdF.pcPlus4 = pcPlus4F;
    end

    stageReg #(.payload_t(fetchToDecode_t)) fdReg (
        .clk(clk), .rst(rst), .stall(stallD), .flush(flushD), .d(fdF), .q(fdD)
    );

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    assign rs1D = fdD.instr[RS1_LSB +: REG_ADDR_W];
    assign rs2D = fdD.instr[RS2_LSB +: REG_ADDR_W];
    assign rdD  = fdD.instr[RD_LSB +: REG_ADDR_W];

    controlDecoder ctrl (
        .opcode(fdD.instr[OPCODE_W-1:0]),
        .funct3(fdD.instr[FUNCT3_LSB +: 3]),
        .funct7b5(fdD.instr[FUNCT7B5_BIT]),
        .regWrite(regWriteD), .aluSrc(aluSrcD), .memWrite(memWriteD),
        .jump(jumpD), .branch(branchD), .immSrc(immSrcD),
        .resultSrc(resultSrcD), .aluOp(aluOpD)
    );

    decodeStage decode (
        .clk(clk), .rst(rst),
        .regWrite(mwW.regWrite), .rs1(rs1D), .rs2(rs2D), .rd(mwW.rd),
        .writeData(resultW), .instr(fdD.instr), .immSrc(immSrcD),
        .readData1(readData1D), .readData2(readData2D), .immExt(immExtD)
    );

    always_comb begin
        deD.pc        = fdD.pc;
        deD.pcPlus4   = fdD.pcPlus4;
        deD.immExt    = immExtD;
        deD.readData1 = readData1D;
        deD.readData2 = readData2D;
        deD.rs1       = rs1D;
        deD.rs2       = rs2D;
        deD.rd        = rdD;
        deD.regWrite  = regWriteD;
        deD.resultSrc = resultSrcD;
        deD.memWrite  = memWriteD;
        deD.jump      = jumpD;
        deD.branch    = branchD;
        deD.aluOp     = aluOpD;
        deD.aluSrc    = aluSrcD;
    end

    stageReg #(.payload_t(decodeToExec_t)) deReg (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flushE), .d(deD), .q(deE)
    );

    //////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////
    executeStage exec (
        .forwardA(forwardA), .forwardB(forwardB), .aluSrc(deE.aluSrc), .aluOp(deE.aluOp),
        .readData1(deE.readData1), .readData2(deE.readData2), .pc(deE.pc),
        .immExt(deE.immExt), .resultW(resultW), .aluResultM(emM.aluResult),
        .aluResult(aluResultE), .writeData(writeDataE), .pcTarget(pcTargetE), .zero(zeroE)
    );

    assign redirectE = (zeroE & deE.branch) | deE.jump;
    assign loadE     = (deE.resultSrc == RES_MEM);   // only lw reads memory

    hazardUnit hazard (
        .rs1D(rs1D), .rs2D(rs2D), .rs1E(deE.rs1), .rs2E(deE.rs2),
        .rdE(deE.rd), .rdM(emM.rd), .rdW(mwW.rd),
        .regWriteM(emM.regWrite), .regWriteW(mwW.regWrite),
        .loadE(loadE), .redirectE(redirectE),
        .forwardA(forwardA), .forwardB(forwardB),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

    always_comb begin
        emE.pcPlus4   = deE.pcPlus4;
        emE.writeData = writeDataE;
        emE.aluResult = aluResultE;
        emE.rd        = deE.rd;
        emE.regWrite  = deE.regWrite;
        emE.resultSrc = deE.resultSrc;
        emE.memWrite  = deE.memWrite;
    end

    stageReg #(.payload_t(execToMem_t)) emReg (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(emE), .q(emM)
    );

    //////////////////////////////////////////////////
    // memory
    //////////////////////////////////////////////////
    assign dmemWrite     = emM.memWrite;   // one strobe per store
    assign dmemAddr      = emM.aluResult;
    assign dmemWriteData = emM.writeData;

    always_comb begin
        mwM.pcPlus4   = emM.pcPlus4;
        mwM.aluResult = emM.aluResult;
        mwM.readData  = dmemReadData;
        mwM.rd        = emM.rd;
        mwM.regWrite  = emM.regWrite;
        mwM.resultSrc = emM.resultSrc;
    end

    stageReg #(.payload_t(memToWb_t)) mwReg (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(mwM), .q(mwW)
    );

    // writeback select
    always_comb begin
        case (mwW.resultSrc)
            RES_ALU: resultW = mwW.aluResult;
            RES_MEM: resultW = mwW.readData;
            RES_PC4: resultW = mwW.pcPlus4;   // jal link
            default: resultW = '0;
        endcase
    end

endmodule

/* verilog/executeStage.sv */
module executeStage (
    input  rvCorePkg::forwardSel_t forwardA,
    input  rvCorePkg::forwardSel_t forwardB,
    input  logic                   aluSrc,
    input  rvCorePkg::aluOp_t      aluOp,
    input  rvCorePkg::dataWord_t   readData1,
    input  rvCorePkg::dataWord_t   readData2,
    input  rvCorePkg::dataWord_t   pc,
    input  rvCorePkg::dataWord_t   immExt,
    input  rvCorePkg::dataWord_t   resultW,
    input  rvCorePkg::dataWord_t   aluResultM,
    output rvCorePkg::dataWord_t   aluResult,
    output rvCorePkg::dataWord_t   writeData,
    output rvCorePkg::dataWord_t   pcTarget,
    output logic                   zero
);
    import rvCorePkg::*;

    dataWord_t fwdA;
    dataWord_t fwdB;
    dataWord_t srcA;
    dataWord_t srcB;

    // bypass mux, same for both operands
    function automatic dataWord_t bypass(forwardSel_t sel, dataWord_t fromRf,
                                         dataWord_t fromWb, dataWord_t fromMem);
        case (sel)
            FWD_WB:  return fromWb;
            FWD_MEM: return fromMem;
            default: return fromRf;
        endcase
    endfunction

    assign fwdA = bypass(forwardA, readData1, resultW, aluResultM);
    assign fwdB = bypass(forwardB, readData2, resultW, aluResultM);

    assign srcA = fwdA;
    assign srcB = aluSrc ? immExt : fwdB;   // immediate for lw, sw, addi

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_SLT: aluResult = (srcA < srcB) ? 32'd1 : 32'd0;   // unsigned compare
            default: aluResult = '0;
        endcase
    end

    assign zero      = (aluResult == '0);   // beq taken when equal
    assign pcTarget  = pc + immExt;         // branch and jal target
    assign writeData = fwdB;                // store data, never the immediate

endmodule

/* verilog/decodeStage.sv */
module decodeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 regWrite,   // from writeback
    input  rvCorePkg::regAddr_t  rs1,
    input  rvCorePkg::regAddr_t  rs2,
    input  rvCorePkg::regAddr_t  rd,
    input  rvCorePkg::dataWord_t writeData,
    input  rvCorePkg::dataWord_t instr,
    input  rvCorePkg::immSrc_t   immSrc,
    output rvCorePkg::dataWord_t readData1,
    output rvCorePkg::dataWord_t readData2,
    output rvCorePkg::dataWord_t immExt
);
    import rvCorePkg::*;

    dataWord_t regs [1:31];   // x0 has no storage

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////
    // falling edge write so decode reads the new value in the same cycle
    always_ff @(negedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin
            regs[rd] <= writeData;
        end
    end

    assign readData1 = (rs1 != '0) ? regs[rs1] : '0;
    assign readData2 = (rs2 != '0) ? regs[rs2] : '0;

    //////////////////////////////////////////////////
    // immediate extension
    //////////////////////////////////////////////////
    always_comb begin
        case (immSrc)
            IMM_I: immExt = {{20{instr[31]}}, instr[31:20]};
            IMM_S: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: immExt = '0;
        endcase
    end

endmodule

/* verilog/hazardUnit.sv */
module hazardUnit (
    input  rvCorePkg::regAddr_t    rs1D,
    input  rvCorePkg::regAddr_t    rs2D,
    input  rvCorePkg::regAddr_t    rs1E,
    input  rvCorePkg::regAddr_t    rs2E,
    input  rvCorePkg::regAddr_t    rdE,
    input  rvCorePkg::regAddr_t    rdM,
    input  rvCorePkg::regAddr_t    rdW,
    input  logic                   regWriteM,
    input  logic                   regWriteW,
    input  logic                   loadE,      // lw sitting in execute
    input  logic                   redirectE,  // taken beq or jal
    output rvCorePkg::forwardSel_t forwardA,
    output rvCorePkg::forwardSel_t forwardB,
    output logic                   stallF,
    output logic                   stallD,
    output logic                   flushD,
    output logic                   flushE
);
    import rvCorePkg::*;

    logic lwStall;

    // memory stage is younger so it takes priority, x0 never forwarded
    function automatic forwardSel_t pickSource(regAddr_t rs, regAddr_t rdMem, logic wrMem,
                                               regAddr_t rdWb, logic wrWb);
        if (rs != '0 && rs == rdMem && wrMem) begin
            return FWD_MEM;
        end else if (rs != '0 && rs == rdWb && wrWb) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign forwardA = pickSource(rs1E, rdM, regWriteM, rdW, regWriteW);
    assign forwardB = pickSource(rs2E, rdM, regWriteM, rdW, regWriteW);

    // load result not ready until memory stage
    assign lwStall = loadE & ((rs1D == rdE) | (rs2D == rdE));

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = redirectE;             // kill wrong-path fetch
    assign flushE = redirectE | lwStall;   // bubble or wrong-path decode

endmodule

/* verilog/controlDecoder.sv */
module controlDecoder (
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic                  funct7b5,
    output logic                  regWrite,
    output logic                  aluSrc,
    output logic                  memWrite,
    output logic                  jump,
    output logic                  branch,
    output rvCorePkg::immSrc_t    immSrc,
    output rvCorePkg::resultSrc_t resultSrc,
    output rvCorePkg::aluOp_t     aluOp
);
    import rvCorePkg::*;

    // coarse alu class from the main decoder
    typedef enum logic [1:0] {CLS_ADD, CLS_SUB, CLS_FUNCT} aluClass_t;

    aluClass_t aluClass;
    logic      rtypeSub;

    //////////////////////////////////////////////////
    // main decoder
    //////////////////////////////////////////////////
    always_comb begin
        regWrite  = 1'b0;   // unknown opcode stays a no-op
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        jump      = 1'b0;
        branch    = 1'b0;
        immSrc    = IMM_I;
        resultSrc = RES_ALU;
        aluClass  = CLS_ADD;
        case (opcode)
            OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_MEM;
            end
            OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSrc   = IMM_S;
            end
            OP_RTYPE: begin
                regWrite = 1'b1;
                aluClass = CLS_FUNCT;
            end
            OP_BRANCH: begin
                branch   = 1'b1;
                immSrc   = IMM_B;
                aluClass = CLS_SUB;   // beq compares by subtracting
            end
            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluClass = CLS_FUNCT;
            end
            OP_JAL: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immSrc    = IMM_J;
                resultSrc = RES_PC4;  // link
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // alu decoder
    //////////////////////////////////////////////////
    assign rtypeSub = funct7b5 & opcode[5];  // addi has opcode bit 5 clear

    always_comb begin
        case (aluClass)
            CLS_SUB: aluOp = ALU_SUB;
            CLS_FUNCT: begin
                case (funct3)
                    3'b000:  aluOp = rtypeSub ? ALU_SUB : ALU_ADD;
                    3'b010:  aluOp = ALU_SLT;
                    3'b110:  aluOp = ALU_OR;
                    3'b111:  aluOp = ALU_AND;
                    default: aluOp = ALU_ADD;
                endcase
            end
            default: aluOp = ALU_ADD;   // address calc for lw, sw
        endcase
    end

endmodule

/* verilog/stageReg.sv */
module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,   // hold current contents
    input  logic     flush,   // sync clear, turns the slot into a bubble
    input  payload_t d,
    output payload_t q
);

    // flush wins over stall
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* verilog/rvCorePkg.sv */
package rvCorePkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int XLEN          = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int IMEM_ADDR_W   = 11;
    localparam int IMEM_ADDR_LSB = 2;   // word address from pc bits 12..2
    localparam int OPCODE_W      = 7;

    typedef logic [XLEN-1:0]        dataWord_t;
    typedef logic [REG_ADDR_W-1:0]  regAddr_t;
    typedef logic [IMEM_ADDR_W-1:0] imemAddr_t;

    //////////////////////////////////////////////////
    // control encodings
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd5    // 4 left unused
    } aluOp_t;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} resultSrc_t;
    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} immSrc_t;
    typedef enum logic [1:0] {FWD_RF, FWD_WB, FWD_MEM} forwardSel_t;

    // opcodes
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_RTYPE  = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;

    // instruction field positions
    localparam int RD_LSB       = 7;
    localparam int FUNCT3_LSB   = 12;
    localparam int RS1_LSB      = 15;
    localparam int RS2_LSB      = 20;
    localparam int FUNCT7B5_BIT = 30;

    //////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        dataWord_t instr;
        dataWord_t pc;
        dataWord_t pcPlus4;
    } fetchToDecode_t;

    typedef struct packed {
        dataWord_t  pc;
        dataWord_t  pcPlus4;
        dataWord_t  immExt;
        dataWord_t  readData1;
        dataWord_t  readData2;
        regAddr_t   rs1;
        regAddr_t   rs2;
        regAddr_t   rd;
        logic       regWrite;
        resultSrc_t resultSrc;
        logic       memWrite;
        logic       jump;
        logic       branch;
        aluOp_t     aluOp;
        logic       aluSrc;
    } decodeToExec_t;

    typedef struct packed {
        dataWord_t  pcPlus4;
        dataWord_t  writeData;
        dataWord_t  aluResult;
        regAddr_t   rd;
        logic       regWrite;
        resultSrc_t resultSrc;
        logic       memWrite;
    } execToMem_t;

    typedef struct packed {
        dataWord_t  pcPlus4;
        dataWord_t  aluResult;
        dataWord_t  readData;
        regAddr_t   rd;
        logic       regWrite;
        resultSrc_t resultSrc;
    } memToWb_t;

endpackage
